// File: design/cw_macros.svh
`ifndef CW_MACROS_SVH
`define CW_MACROS_SVH

// host register map
`define CW_TRIGSRC_ADDR       8'd39   // trigger source, two bytes
`define CW_TRIGMOD_ADDR       8'd40   // trigger module select
`define USERIO_CW_DRIVEN      8'd58   // user io direction
`define USERIO_DEBUG_DRIVEN   8'd59   // fpga debug, target debug, swd flags
`define USERIO_DEBUG_SELECT   8'd60   // fpga debug mux select
`define USERIO_DRIVE_DATA     8'd61   // user io output data
`define USERIO_READ           8'd62   // user io pin readback

// combine mode field inside the trigger source register
`define TRIG_MODE_LSB         6
`define TRIG_MODE_MSB         7
`define TRIG_MODE_OR          2'd0
`define TRIG_MODE_AND         2'd1
`define TRIG_MODE_NAND        2'd2    // code 3 forces a zero trigger

// module select field inside the trigger module register
`define TRIGMOD_SEL_LSB       0
`define TRIGMOD_SEL_MSB       2
`define TRIGMOD_EXT           3'd0
`define TRIGMOD_ADVIO         3'd1
`define TRIGMOD_SAD           3'd2
`define TRIGMOD_DECODEIO      3'd3
`define TRIGMOD_TRACE         3'd4
`define TRIGMOD_ADC           3'd5
`define TRIGMOD_EDGE          3'd6    // code 7 forces a zero trigger

`define TRIGSRC_RESET         16'h0020  // io4 only, or mode
`define TRIGMOD_RESET         8'h00

// direction patterns for the debug overrides
`define SWD_DIR_CLK_LOW       8'h20
`define SWD_DIR_CLK_HIGH      8'h60
`define JTAG_DIR              8'he0

`endif

// File: design/cw_pkg.sv
package cw_pkg;

   // host register bus
   typedef logic [7:0] reg_addr_t;   // register address
   typedef logic [7:0] reg_byte_t;   // one data byte
   typedef logic [6:0] byte_cnt_t;   // byte index in a wide register

   // trigger source layout
   //   [0]     aux pin enable
   //   [1]     nrst pin enable
   //   [5:2]   io1..io4 enables
   //   [7:6]   combine mode
   //   [15:8]  userio_d 0..7 enables
   typedef logic [15:0] trig_src_t;

   // trigger module register
   //   [2:0]   module select, upper bits spare
   typedef logic [7:0] trig_mod_t;

   // user io pins, direction and drive data
   typedef logic [7:0] userio_t;

   // pins feeding the external combiner
   // 6 fixed trigger pins plus the 8 user io lines
   typedef logic [13:0] ext_pins_t;

endpackage

// File: design/cw_reg_file.sv
`include "cw_macros.svh"

module cw_reg_file (
   input  logic              clk_usb,
   input  logic              reset,
   input  cw_pkg::reg_addr_t reg_address_i,
   input  cw_pkg::byte_cnt_t reg_bytecnt_i,
   input  cw_pkg::reg_byte_t reg_datai_i,
   input  logic              reg_write_i,
   input  logic              reg_read_i,
   input  logic              trace_en_i,
   input  cw_pkg::userio_t   trace_userio_dir_i,
   input  cw_pkg::userio_t   userio_d_i,
   input  logic              userio_clk_i,
   output cw_pkg::reg_byte_t reg_datao_o,
   output cw_pkg::trig_src_t trig_src_o,
   output cw_pkg::trig_mod_t trig_mod_o,
   output cw_pkg::userio_t   userio_cwdriven_o,
   output cw_pkg::userio_t   userio_drive_data_o,
   output logic              userio_fpga_debug_o,
   output logic              userio_target_debug_o,
   output logic              userio_target_debug_swd_o,
   output logic [3:0]        userio_fpga_debug_select_o
);

   cw_pkg::userio_t userio_dir_q;   // direction as written by the host
   logic            byte0;          // first byte of a wide register
   logic            byte1;          // second byte

   assign byte0 = (reg_bytecnt_i == 7'd0);
   assign byte1 = (reg_bytecnt_i == 7'd1);

   // write decode, one byte per strobe
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trig_src_o                 <= `TRIGSRC_RESET;
         trig_mod_o                 <= `TRIGMOD_RESET;
         userio_dir_q               <= 8'h00;   // all user io as inputs
         userio_drive_data_o        <= 8'h00;
         userio_fpga_debug_o        <= 1'b0;
         userio_target_debug_o      <= 1'b0;
         userio_target_debug_swd_o  <= 1'b0;
         userio_fpga_debug_select_o <= 4'h0;
      end else if (reg_write_i) begin
         case (reg_address_i)
            `CW_TRIGSRC_ADDR: begin
               if (byte0) begin
                  trig_src_o[7:0] <= reg_datai_i;    // pin enables and mode
               end else if (byte1) begin
                  trig_src_o[15:8] <= reg_datai_i;   // userio_d enables
               end
            end
            `CW_TRIGMOD_ADDR: trig_mod_o <= reg_datai_i;
            `USERIO_CW_DRIVEN: begin
               if (byte0) begin
                  userio_dir_q <= reg_datai_i;
               end
            end
            `USERIO_DEBUG_DRIVEN: begin
               userio_fpga_debug_o       <= reg_datai_i[0];
               userio_target_debug_o     <= reg_datai_i[1];
               userio_target_debug_swd_o <= reg_datai_i[2];
            end
            `USERIO_DEBUG_SELECT: userio_fpga_debug_select_o <= reg_datai_i[3:0];
            `USERIO_DRIVE_DATA: begin
               if (byte0) begin
                  userio_drive_data_o <= reg_datai_i;
               end
            end
            default: ;   // read-only or unmapped
         endcase
      end
   end

   // direction override, highest priority first
   always_comb begin
      if (trace_en_i) begin
         userio_cwdriven_o = trace_userio_dir_i;   // trace port owns the pins
      end else if (userio_fpga_debug_o) begin
         userio_cwdriven_o = 8'hff;                // every line is an output
      end else if (userio_target_debug_o && userio_target_debug_swd_o) begin
         // swdio turns around with the clock
         userio_cwdriven_o = userio_clk_i ? `SWD_DIR_CLK_HIGH : `SWD_DIR_CLK_LOW;
      end else if (userio_target_debug_o) begin
         userio_cwdriven_o = `JTAG_DIR;
      end else begin
         userio_cwdriven_o = userio_dir_q;
      end
   end

   // readback mux, zero unless a read is in progress
   always_comb begin
      reg_datao_o = 8'h00;
      if (reg_read_i) begin
         case (reg_address_i)
            `CW_TRIGSRC_ADDR: begin
               if (byte0) begin
                  reg_datao_o = trig_src_o[7:0];
               end else if (byte1) begin
                  reg_datao_o = trig_src_o[15:8];
               end
            end
            `CW_TRIGMOD_ADDR: reg_datao_o = trig_mod_o;
            `USERIO_CW_DRIVEN: begin
               if (byte0) begin
                  reg_datao_o = userio_cwdriven_o;   // value after override
               end
            end
            `USERIO_DEBUG_DRIVEN: reg_datao_o = {5'b0, userio_target_debug_swd_o,
                                                 userio_target_debug_o, userio_fpga_debug_o};
            `USERIO_DEBUG_SELECT: reg_datao_o = {4'b0, userio_fpga_debug_select_o};
            `USERIO_DRIVE_DATA: begin
               if (byte0) begin
                  reg_datao_o = userio_drive_data_o;
               end
            end
            `USERIO_READ: begin
               if (byte0) begin
                  reg_datao_o = userio_d_i;              // live pins
               end else if (byte1) begin
                  reg_datao_o = {7'b0, userio_clk_i};    // clock line in bit 0
               end
            end
            default: reg_datao_o = 8'h00;
         endcase
      end
   end

endmodule

// File: design/ext_trigger_combiner.sv
`include "cw_macros.svh"

module ext_trigger_combiner (
   input  cw_pkg::trig_src_t trig_src_i,
   input  logic              trigger_aux_i,
   input  logic              trigger_nrst_i,
   input  logic              trigger_io1_i,
   input  logic              trigger_io2_i,
   input  logic              trigger_io3_i,
   input  logic              trigger_io4_i,
   input  cw_pkg::userio_t   userio_d_i,
   output logic              trigger_ext_o
);

   cw_pkg::ext_pins_t pins;       // candidate pins in register bit order
   cw_pkg::ext_pins_t pin_en;     // matching enable bits
   logic [1:0]        mode;
   logic              trig_or;
   logic              trig_and;

   // bits 7:6 of the register are the mode so the enables skip them
   assign pins   = {userio_d_i, trigger_io4_i, trigger_io3_i, trigger_io2_i,
                    trigger_io1_i, trigger_nrst_i, trigger_aux_i};
   assign pin_en = {trig_src_i[15:8], trig_src_i[5:0]};
   assign mode   = trig_src_i[`TRIG_MODE_MSB:`TRIG_MODE_LSB];

   // any enabled pin high
   assign trig_or  = |(pins & pin_en);
   // disabled pins count as high so no enables gives 1
   assign trig_and = &(pins | ~pin_en);

   always_comb begin
      case (mode)
         `TRIG_MODE_OR:   trigger_ext_o = trig_or;
         `TRIG_MODE_AND:  trigger_ext_o = trig_and;
         `TRIG_MODE_NAND: trigger_ext_o = ~trig_and;
         default:         trigger_ext_o = 1'b0;   // spare code
      endcase
   end

endmodule

// File: design/trigger_router.sv
`include "cw_macros.svh"

module trigger_router (
   input  cw_pkg::trig_mod_t trig_mod_i,
   input  logic              trigger_ext_i,
   input  logic              trigger_advio_i,
   input  logic              trigger_sad_i,
   input  logic              trigger_decodedio_i,
   input  logic              trigger_trace_i,
   input  logic              trigger_adc_i,
   input  logic              trigger_edge_i,
   output logic              trigger_capture_o,
   output logic              decodeio_active_o,
   output logic              sad_active_o,
   output logic              edge_trigger_active_o
);

   logic [2:0] mod_sel;   // module code, upper register bits ignored

   assign mod_sel = trig_mod_i[`TRIGMOD_SEL_MSB:`TRIGMOD_SEL_LSB];

   // capture trigger mux
   always_comb begin
      case (mod_sel)
         `TRIGMOD_EXT:      trigger_capture_o = trigger_ext_i;   // combined pins
         `TRIGMOD_ADVIO:    trigger_capture_o = trigger_advio_i;
         `TRIGMOD_SAD:      trigger_capture_o = trigger_sad_i;
         `TRIGMOD_DECODEIO: trigger_capture_o = trigger_decodedio_i;
         `TRIGMOD_TRACE:    trigger_capture_o = trigger_trace_i;
         `TRIGMOD_ADC:      trigger_capture_o = trigger_adc_i;
         `TRIGMOD_EDGE:     trigger_capture_o = trigger_edge_i;
         default:           trigger_capture_o = 1'b0;   // code 7
      endcase
   end

   // enables for the modules that need to know they own the trigger
   // at most one is high since they decode the same field
   assign decodeio_active_o     = (mod_sel == `TRIGMOD_DECODEIO);
   assign sad_active_o          = (mod_sel == `TRIGMOD_SAD);
   assign edge_trigger_active_o = (mod_sel == `TRIGMOD_EDGE);

endmodule

// File: design/cw_trigger_top.sv
module cw_trigger_top (
   input  logic              clk_usb,
   input  logic              reset,
   // host register bus
   input  cw_pkg::reg_addr_t reg_address_i,
   input  cw_pkg::byte_cnt_t reg_bytecnt_i,
   input  cw_pkg::reg_byte_t reg_datai_i,
   input  logic              reg_write_i,
   input  logic              reg_read_i,
   output cw_pkg::reg_byte_t reg_datao_o,
   // external trigger pins
   input  logic              trigger_aux_i,
   input  logic              trigger_nrst_i,
   input  logic              trigger_io1_i,
   input  logic              trigger_io2_i,
   input  logic              trigger_io3_i,
   input  logic              trigger_io4_i,
   // triggers from the capture modules
   input  logic              trigger_advio_i,
   input  logic              trigger_sad_i,
   input  logic              trigger_decodedio_i,
   input  logic              trigger_trace_i,
   input  logic              trigger_adc_i,
   input  logic              trigger_edge_i,
   // user io and trace
   input  logic              trace_en_i,
   input  cw_pkg::userio_t   trace_userio_dir_i,
   input  cw_pkg::userio_t   userio_d_i,
   input  logic              userio_clk_i,
   output logic              trigger_capture_o,
   output logic              trigger_ext_o,
   output logic              decodeio_active_o,
   output logic              sad_active_o,
   output logic              edge_trigger_active_o,
   output cw_pkg::userio_t   userio_cwdriven_o,
   output cw_pkg::userio_t   userio_drive_data_o,
   output logic              userio_fpga_debug_o,
   output logic              userio_target_debug_o,
   output logic              userio_target_debug_swd_o,
   output logic [3:0]        userio_fpga_debug_select_o
);

   cw_pkg::trig_src_t trig_src;   // to the pin combiner
   cw_pkg::trig_mod_t trig_mod;   // to the router

   cw_reg_file cw_reg_file_i (
      .clk_usb                    (clk_usb),
      .reset                      (reset),
      .reg_address_i              (reg_address_i),
      .reg_bytecnt_i              (reg_bytecnt_i),
      .reg_datai_i                (reg_datai_i),
      .reg_write_i                (reg_write_i),
      .reg_read_i                 (reg_read_i),
      .trace_en_i                 (trace_en_i),
      .trace_userio_dir_i         (trace_userio_dir_i),
      .userio_d_i                 (userio_d_i),
      .userio_clk_i               (userio_clk_i),
      .reg_datao_o                (reg_datao_o),
      .trig_src_o                 (trig_src),
      .trig_mod_o                 (trig_mod),
      .userio_cwdriven_o          (userio_cwdriven_o),
      .userio_drive_data_o        (userio_drive_data_o),
      .userio_fpga_debug_o        (userio_fpga_debug_o),
      .userio_target_debug_o      (userio_target_debug_o),
      .userio_target_debug_swd_o  (userio_target_debug_swd_o),
      .userio_fpga_debug_select_o (userio_fpga_debug_select_o)
   );

   ext_trigger_combiner ext_trigger_combiner_i (
      .trig_src_i     (trig_src),
      .trigger_aux_i  (trigger_aux_i),
      .trigger_nrst_i (trigger_nrst_i),
      .trigger_io1_i  (trigger_io1_i),
      .trigger_io2_i  (trigger_io2_i),
      .trigger_io3_i  (trigger_io3_i),
      .trigger_io4_i  (trigger_io4_i),
      .userio_d_i     (userio_d_i),
      .trigger_ext_o  (trigger_ext_o)   // also feeds the router
   );

   trigger_router trigger_router_i (
      .trig_mod_i            (trig_mod),
      .trigger_ext_i         (trigger_ext_o),
      .trigger_advio_i       (trigger_advio_i),
      .trigger_sad_i         (trigger_sad_i),
      .trigger_decodedio_i   (trigger_decodedio_i),
      .trigger_trace_i       (trigger_trace_i),
      .trigger_adc_i         (trigger_adc_i),
      .trigger_edge_i        (trigger_edge_i),
      .trigger_capture_o     (trigger_capture_o),
      .decodeio_active_o     (decodeio_active_o),
      .sad_active_o          (sad_active_o),
      .edge_trigger_active_o (edge_trigger_active_o)
   );

endmodule

// File: testbench/cw_trigger_asserts.sv
`include "cw_macros.svh"

module cw_trigger_asserts (
   input logic       clk_usb,
   input logic       reset,
   input logic [7:0] reg_address_i,
   input logic       reg_write_i,
   input logic       reg_read_i,
   input logic [7:0] reg_datao_o,
   input logic       decodeio_active_o,
   input logic       sad_active_o,
   input logic       edge_trigger_active_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // bus is quiet between reads
   read_idle_zero: assert property (@(posedge clk_usb) disable iff (reset)
      !reg_read_i |-> (reg_datao_o == 8'h00))
      else $error("read data not zero while no read is active");

   // flags only move on the cycle after a trigger module write
   flags_follow_write: assert property (@(posedge clk_usb) disable iff (reset)
      !$stable({decodeio_active_o, sad_active_o, edge_trigger_active_o})
      |-> $past(reg_write_i && (reg_address_i == `CW_TRIGMOD_ADDR)))
      else $error("module active flag changed without a trigger module write");

   flags_low_after_reset: assert property (@(posedge clk_usb)
      reset |=> !(decodeio_active_o || sad_active_o || edge_trigger_active_o))
      else $error("module active flag high right after reset");

endmodule

bind cw_trigger_top cw_trigger_asserts cw_trigger_asserts_i (
   .clk_usb               (clk_usb),
   .reset                 (reset),
   .reg_address_i         (reg_address_i),
   .reg_write_i           (reg_write_i),
   .reg_read_i            (reg_read_i),
   .reg_datao_o           (reg_datao_o),
   .decodeio_active_o     (decodeio_active_o),
   .sad_active_o          (sad_active_o),
   .edge_trigger_active_o (edge_trigger_active_o)
);

// File: testbench/tb_cw_trigger.sv
`include "cw_macros.svh"

module tb_cw_trigger;
   timeunit 1ns;
   timeprecision 1ps;

   localparam string DATA_FILE = "testbench/cw_trigger_testdata.txt";

   logic              clk_usb;
   logic              reset;
   cw_pkg::reg_addr_t reg_address_i;
   cw_pkg::byte_cnt_t reg_bytecnt_i;
   cw_pkg::reg_byte_t reg_datai_i;
   logic              reg_write_i;
   logic              reg_read_i;
   cw_pkg::reg_byte_t reg_datao_o;
   logic              trigger_aux_i;
   logic              trigger_nrst_i;
   logic              trigger_io1_i;
   logic              trigger_io2_i;
   logic              trigger_io3_i;
   logic              trigger_io4_i;
   logic              trigger_advio_i;
   logic              trigger_sad_i;
   logic              trigger_decodedio_i;
   logic              trigger_trace_i;
   logic              trigger_adc_i;
   logic              trigger_edge_i;
   logic              trace_en_i;
   cw_pkg::userio_t   trace_userio_dir_i;
   cw_pkg::userio_t   userio_d_i;
   logic              userio_clk_i;
   logic              trigger_capture_o;
   logic              trigger_ext_o;
   logic              decodeio_active_o;
   logic              sad_active_o;
   logic              edge_trigger_active_o;
   cw_pkg::userio_t   userio_cwdriven_o;
   cw_pkg::userio_t   userio_drive_data_o;
   logic              userio_fpga_debug_o;
   logic              userio_target_debug_o;
   logic              userio_target_debug_swd_o;
   logic [3:0]        userio_fpga_debug_select_o;

   integer           fd;
   integer           rc;
   integer           n_lines;          // sizes the watchdog
   integer           seed;
   logic [7:0]       op;               // opcode letter
   logic [31:0]      f1, f2, f3, f4;   // hex fields of one line
   logic [8*128-1:0] line;

   cw_trigger_top cw_trigger_top_i (.*);

   initial begin
      clk_usb = 1'b0;
      forever #4 clk_usb = ~clk_usb;   // 125 MHz
   end

   task automatic stop_run();
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
      assert (got === exp) else begin
         $display("mismatch %s exp=%h got=%h", name, exp, got);
         stop_run();
      end
   endtask

   // pins that no check depends on get noise
   task automatic fill_trigger_pins();
      logic [31:0] rnd;
      rnd = $random(seed);
      {trigger_io4_i, trigger_io3_i, trigger_io2_i,
       trigger_io1_i, trigger_nrst_i, trigger_aux_i} = rnd[5:0];
      {trigger_edge_i, trigger_adc_i, trigger_trace_i,
       trigger_decodedio_i, trigger_sad_i, trigger_advio_i} = rnd[11:6];
   endtask

   initial begin
      seed               = 16;
      n_lines            = 0;
      reset              = 1'b1;
      reg_address_i      = '0;
      reg_bytecnt_i      = '0;
      reg_datai_i        = '0;
      reg_write_i        = 1'b0;
      reg_read_i         = 1'b0;
      trace_en_i         = 1'b0;
      trace_userio_dir_i = '0;
      userio_d_i         = '0;
      userio_clk_i       = 1'b0;
      fill_trigger_pins();

      fd = $fopen(DATA_FILE, "r");
      if (fd == 0) begin
         $display("could not open the test data file");
         stop_run();
      end
      while (!$feof(fd)) begin   // first pass only counts lines
         rc = $fgets(line, fd);
         if (rc > 0) n_lines++;
      end
      $fclose(fd);
      fd = $fopen(DATA_FILE, "r");

      repeat (3) @(posedge clk_usb);
      @(negedge clk_usb);
      reset = 1'b0;

      while ($fscanf(fd, " %c", op) == 1) begin
         if (op == "#") begin
            rc = $fgets(line, fd);   // column notes
         end else begin
            @(negedge clk_usb);
            reg_write_i = 1'b0;      // strobes last one cycle
            reg_read_i  = 1'b0;
            if (op != "T") fill_trigger_pins();
            case (op)
               "W", "R": begin
                  rc            = $fscanf(fd, "%h %h %h", f1, f2, f3);
                  reg_address_i = f1[7:0];
                  reg_bytecnt_i = f2[6:0];
                  reg_datai_i   = (op == "W") ? f3[7:0] : 8'h00;
                  reg_write_i   = (op == "W");
                  reg_read_i    = (op == "R");
               end
               "T": begin
                  rc = $fscanf(fd, "%h %h %h", f1, f2, f3);
                  {trigger_edge_i, trigger_adc_i, trigger_trace_i,
                   trigger_decodedio_i, trigger_sad_i, trigger_advio_i} = f1[19:14];
                  userio_d_i = f1[13:6];
                  {trigger_io4_i, trigger_io3_i, trigger_io2_i,
                   trigger_io1_i, trigger_nrst_i, trigger_aux_i} = f1[5:0];
               end
               "U": begin
                  rc                 = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                  trace_en_i         = f1[0];
                  trace_userio_dir_i = f2[7:0];
                  userio_clk_i       = f3[0];
               end
               "A": rc = $fscanf(fd, "%h", f1);
               default: begin
                  $display("unknown opcode in the test data");
                  stop_run();
               end
            endcase
            // sample late in the cycle, well after the posedge updates
            @(posedge clk_usb);
            #3;
            case (op)
               "W": begin
                  // written fields show up on the matching output ports
                  case (f1[7:0])
                     `USERIO_DEBUG_DRIVEN: begin
                        check_value("userio_fpga_debug_o", {7'b0, f3[0]},
                                    {7'b0, userio_fpga_debug_o});
                        check_value("userio_target_debug_o", {7'b0, f3[1]},
                                    {7'b0, userio_target_debug_o});
                        check_value("userio_target_debug_swd_o", {7'b0, f3[2]},
                                    {7'b0, userio_target_debug_swd_o});
                     end
                     `USERIO_DEBUG_SELECT:
                        check_value("userio_fpga_debug_select_o", {4'b0, f3[3:0]},
                                    {4'b0, userio_fpga_debug_select_o});
                     `USERIO_DRIVE_DATA:
                        check_value("userio_drive_data_o", f3[7:0], userio_drive_data_o);
                     default: ;
                  endcase
               end
               "R": check_value("reg_datao_o", f3[7:0], reg_datao_o);
               "T": begin
                  check_value("trigger_ext_o", f2[7:0], {7'b0, trigger_ext_o});
                  check_value("trigger_capture_o", f3[7:0], {7'b0, trigger_capture_o});
               end
               "U": check_value("userio_cwdriven_o", f4[7:0], userio_cwdriven_o);
               "A": check_value("active_flags", f1[7:0],
                                {5'b0, edge_trigger_active_o, sad_active_o, decodeio_active_o});
               default: ;
            endcase
         end
      end

      @(negedge clk_usb);
      reg_write_i = 1'b0;
      reg_read_i  = 1'b0;
      $fclose(fd);
      $display("STATUS: PASS");
      $finish;
   end

   // every line takes one cycle, so ten per line is plenty
   initial begin
      wait (n_lines > 0);
      repeat (n_lines * 10 + 100) @(posedge clk_usb);
      $display("timeout: test data not finished");
      stop_run();
   end

endmodule

// File: testbench/cw_trigger_testdata.txt
# hex fields: W addr cnt data | R addr cnt exp | A flags {edge,sad,decodeio}
# T pins{edge,adc,trace,decio,sad,advio,userio_d[7:0],io4..io1,nrst,aux} ext cap
# U trace_en dir clk exp_cwdriven
R 27 0 20
R 27 1 00
R 28 0 00
A 0
W 27 0 a5
W 27 1 3c
R 27 0 a5
R 27 1 3c
W 27 1 81
R 27 0 a5
R 27 1 81
W 27 1 04
W 27 0 14
T 00000 0 0
T 00004 1 1
T 03eeb 0 0
W 27 0 54
T 00114 1 1
T 00104 0 0
W 27 0 94
T 00114 0 0
T 00104 1 1
W 27 0 d4
T 03fff 0 0
W 27 1 00
W 27 0 40
T 00000 1 1
W 27 0 04
T 00004 1 1
W 28 0 01
T fbfff 1 0
T 04000 0 1
W 28 0 02
T 08000 0 1
A 2
W 28 0 03
T 10000 0 1
A 1
W 28 0 04
T 20000 0 1
W 28 0 05
T 40000 0 1
W 28 0 06
T 80000 0 1
A 4
W 28 0 07
T fffff 1 0
A 0
R 28 0 07
W 3a 0 5a
U 1 c3 0 c3
W 3b 0 07
U 1 c3 0 c3
U 0 c3 0 ff
W 3b 0 06
U 0 00 0 20
U 0 00 1 60
R 3a 0 60
W 3b 0 02
U 0 00 0 e0
W 3b 0 00
U 0 00 0 5a
R 3a 0 5a
R 3b 0 00
W 3d 0 96
R 3d 0 96
W 3c 0 0b
R 3c 0 0b
T 02a40 0 0
U 0 00 1 5a
R 3e 0 a9
R 3e 1 01
R 50 0 00

// File: build.f
+incdir+design
design/cw_pkg.sv
design/cw_reg_file.sv
design/ext_trigger_combiner.sv
design/trigger_router.sv
design/cw_trigger_top.sv
testbench/cw_trigger_asserts.sv
testbench/tb_cw_trigger.sv

// File: Makefile
TOP = tb_cw_trigger

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
